/* Bender.yml */
package:
  name: party_box

sources:
  - files:
      - design/party_pkg.sv
      - design/button_sync.sv
      - design/countdown_timer.sv
      - design/round_control.sv
      - design/hex_display.sv
      - design/video_driver.sv
      - design/party_box.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_party_box.sv

/* design/button_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module button_sync
	import party_pkg::*;
#(
	parameter int DEBOUNCE_CYCLES = 500_000 // Cycles an input must hold a new level.
) (
	input  wire        CLOCK_50,
	input  wire        arst_n,
	input  wire  [3:0] key,    // Board keys are active low.
	input  wire        buzzer, // External buzzer is active high.
	output press_t     press
);

	localparam int NCH = 4; // KEY[0], KEY[2], KEY[3] and the buzzer.
	localparam int CW = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES) : 1;

	wire  [NCH-1:0] raw;    // All channels turned active high.
	logic [NCH-1:0] sync_a; // First synchronizer stage.
	logic [NCH-1:0] sync_b; // Second synchronizer stage.
	wire  [NCH-1:0] rise;   // Debounced press edges.

	assign raw = {buzzer, ~key[3], ~key[2], ~key[0]};

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			sync_a <= '0; // Zero means released on every channel.
			sync_b <= '0;
		end else begin
			sync_a <= raw;
			sync_b <= sync_a;
		end
	end

	for (genvar i = 0; i < NCH; i++) begin : g_channel
		logic [CW-1:0] cnt;   // Cycles the synced input has differed from level.
		logic          level; // Accepted debounced level.
		logic          pulse; // One-cycle pulse on an accepted press.

		always_ff @(posedge CLOCK_50 or negedge arst_n) begin
			if (!arst_n) begin
				cnt <= '0;
				level <= 1'b0;
				pulse <= 1'b0;
			end else begin
				pulse <= 1'b0;
				if (sync_b[i] == level) begin
					cnt <= '0; // Any bounce back restarts the wait.
				end else if (cnt == CW'(DEBOUNCE_CYCLES - 1)) begin
					cnt <= '0;
					level <= sync_b[i];
					pulse <= sync_b[i]; // Only the press edge counts, not the release.
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
		end

		assign rise[i] = pulse;
	end

	assign press = '{start: rise[0], player_a: rise[2] | rise[3], player_b: rise[1]};

endmodule

`default_nettype wire

/* design/countdown_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module countdown_timer
	import party_pkg::*;
#(
	parameter int TICKS_PER_STEP = 50_000_000 // Clock cycles per countdown step.
) (
	input  wire         CLOCK_50,
	input  wire         arst_n,
	input  wire         load,       // Restarts the count from load_value.
	input  wire digit_t load_value,
	output digit_t      digit,      // Digit shown on HEX0.
	output logic        done        // High in the cycle the digit becomes zero.
);

	localparam int CW = (TICKS_PER_STEP > 1) ? $clog2(TICKS_PER_STEP) : 1;

	logic [CW-1:0] tick_cnt; // Prescaler inside one step.
	logic          step;     // Last cycle of the current step.

	assign step = (tick_cnt == CW'(TICKS_PER_STEP - 1));

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			tick_cnt <= '0;
			digit <= '0; // HEX0 reads zero before the first round.
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (load) begin
				tick_cnt <= '0; // A fresh load gives a full first step.
				digit <= load_value;
			end else if (digit != '0) begin
				if (step) begin
					tick_cnt <= '0;
					digit <= digit - 4'd1;
					done <= (digit == 4'd1); // Lands together with the zero digit.
				end else begin
					tick_cnt <= tick_cnt + 1'b1;
				end
			end
			// At zero both counters hold until the next load.
		end
	end

endmodule

`default_nettype wire

/* design/hex_display.sv */
`timescale 1ns/1ps
`default_nettype none

module hex_display
	import party_pkg::*;
(
	input  wire                CLOCK_50,
	input  wire                arst_n,
	input  wire digit_t        digit,  // Countdown digit for HEX0.
	input  wire round_status_t status, // Carries both scores.
	output logic         [6:0] hex0,
	output logic         [6:0] hex1,
	output logic         [6:0] hex2,
	output logic         [6:0] hex3,
	output logic         [6:0] hex4,
	output logic         [6:0] hex5
);

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			hex0 <= seg_of(4'd0); // Zero on all three live displays after reset.
			hex4 <= seg_of(4'd0);
			hex5 <= seg_of(4'd0);
		end else begin
			hex0 <= seg_of(digit);
			hex4 <= seg_of(status.score_b); // Player B sits on the right.
			hex5 <= seg_of(status.score_a); // Player A sits on the far left.
		end
	end

	assign hex1 = SEG_BLANK; // The middle three displays stay dark.
	assign hex2 = SEG_BLANK;
	assign hex3 = SEG_BLANK;

endmodule

`default_nettype wire

/* design/party_box.sv */
`timescale 1ns/1ps
`default_nettype none

module party_box
	import party_pkg::*;
#(
	parameter int TICKS_PER_STEP = 50_000_000, // One countdown step per second at 50 MHz.
	parameter int DEBOUNCE_CYCLES = 500_000,   // Ten milliseconds of stable input.
	parameter int WIDTH = 640,
	parameter int HEIGHT = 480
) (
	input  wire        CLOCK_50,
	input  wire        arst_n,
	input  wire  [3:0] KEY,
	input  wire  [9:0] SW,
	input  wire [35:0] GPIO_1,
	output logic [6:0] HEX0,
	output logic [6:0] HEX1,
	output logic [6:0] HEX2,
	output logic [6:0] HEX3,
	output logic [6:0] HEX4,
	output logic [6:0] HEX5,
	output logic [9:0] LEDR,
	output logic [7:0] VGA_R,
	output logic [7:0] VGA_G,
	output logic [7:0] VGA_B,
	output logic       VGA_BLANK_N,
	output logic       VGA_CLK,
	output logic       VGA_HS,
	output logic       VGA_SYNC_N,
	output logic       VGA_VS
);

	press_t        press;      // One-cycle press pulses after debouncing.
	round_status_t status;     // Winner, countdown flag and both scores.
	logic          load;       // Pulse that restarts the countdown.
	digit_t        load_value; // Clamped start digit for the timer.
	digit_t        digit;      // Current countdown digit.
	logic          done;       // Pulse when the digit reaches zero.
	rgb_t          colour;     // Full-screen colour for this result.

	button_sync #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_button_sync (
		.CLOCK_50, .arst_n, .key(KEY), .buzzer(GPIO_1[0]), .press
	); // Only GPIO_1[0] carries the buzzer.

	round_control i_round_control (
		.CLOCK_50, .arst_n, .press, .start_value(SW[3:0]), .done, .load, .load_value, .status
	); // SW[9:4] have no function in this game.

	countdown_timer #(.TICKS_PER_STEP(TICKS_PER_STEP)) i_countdown_timer (
		.CLOCK_50, .arst_n, .load, .load_value, .digit, .done
	);

	hex_display i_hex_display (
		.CLOCK_50, .arst_n, .digit, .status,
		.hex0(HEX0), .hex1(HEX1), .hex2(HEX2), .hex3(HEX3), .hex4(HEX4), .hex5(HEX5)
	);

	always_comb begin
		case (status.winner)
			win_a: begin
				LEDR = 10'b11111_00000; // Left half belongs to player A.
				colour = COLOUR_A;
			end
			win_b: begin
				LEDR = 10'b00000_11111; // Right half belongs to player B.
				colour = COLOUR_B;
			end
			win_tie: begin
				LEDR = 10'b11111_11111; // Every LED lights on a tie.
				colour = COLOUR_TIE;
			end
			default: begin
				LEDR = 10'b00000_00000; // Dark while waiting or counting.
				colour = COLOUR_IDLE;
			end
		endcase
	end

	video_driver #(.WIDTH(WIDTH), .HEIGHT(HEIGHT)) i_video_driver (
		.CLOCK_50, .arst_n, .colour,
		.vga_r(VGA_R), .vga_g(VGA_G), .vga_b(VGA_B), .vga_blank_n(VGA_BLANK_N),
		.vga_clk(VGA_CLK), .vga_hs(VGA_HS), .vga_vs(VGA_VS)
	);

	assign VGA_SYNC_N = 1'b1; // Sync on green is not used by this DAC.

endmodule

`default_nettype wire

/* design/party_pkg.sv */
`default_nettype none

package party_pkg;

	typedef logic [3:0] digit_t; // One decimal digit, kept in the range 0 to 9.

	typedef struct packed {
		logic start;    // Start or next-round request from KEY[0].
		logic player_a; // Player A pressed KEY[3] or hit the buzzer.
		logic player_b; // Player B pressed KEY[2].
	} press_t;

	typedef enum logic [1:0] {
		win_none, // No result yet in this round.
		win_a,    // Player A took the round.
		win_b,    // Player B took the round.
		win_tie   // Both players in the same cycle.
	} winner_e;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	typedef struct packed {
		winner_e winner;  // Outcome of the current or last round.
		logic    counting; // High while the countdown is running.
		digit_t  score_a; // Wins of player A modulo ten.
		digit_t  score_b; // Wins of player B modulo ten.
	} round_status_t;

	localparam logic [6:0] SEG_BLANK = 7'b1111111; // Segments are active low so all ones is dark.

	localparam rgb_t COLOUR_IDLE = '{r: 8'hff, g: 8'hff, b: 8'hff}; // White waiting screen.
	localparam rgb_t COLOUR_A = '{r: 8'hff, g: 8'h00, b: 8'h00}; // Red for player A.
	localparam rgb_t COLOUR_B = '{r: 8'h00, g: 8'h00, b: 8'hff}; // Blue for player B.
	localparam rgb_t COLOUR_TIE = '{r: 8'h00, g: 8'hff, b: 8'h00}; // Green for a tie.

	// Segment order is g f e d c b a from the top bit down.
	function automatic logic [6:0] seg_of(input digit_t d);
		case (d)
			4'd0: return 7'b1000000;
			4'd1: return 7'b1111001;
			4'd2: return 7'b0100100;
			4'd3: return 7'b0110000;
			4'd4: return 7'b0011001;
			4'd5: return 7'b0010010;
			4'd6: return 7'b0000010;
			4'd7: return 7'b1111000;
			4'd8: return 7'b0000000;
			4'd9: return 7'b0010000;
			default: return SEG_BLANK; // Codes above nine never reach a display.
		endcase
	endfunction

endpackage

`default_nettype wire

/* design/round_control.sv */
`timescale 1ns/1ps
`default_nettype none

module round_control
	import party_pkg::*;
(
	input  wire           CLOCK_50,
	input  wire           arst_n,
	input  wire press_t   press,       // Debounced press pulses.
	input  wire     [3:0] start_value, // Raw switch value for the countdown.
	input  wire           done,        // Countdown reached zero.
	output logic          load,        // Restarts the countdown timer.
	output digit_t        load_value,  // Start digit in the range 1 to 9.
	output round_status_t status
);

	typedef enum logic [1:0] {
		st_idle,     // Waiting for the first start after reset.
		st_counting, // Countdown runs and presses are false starts.
		st_armed,    // First valid press wins.
		st_result    // Result shown until the next start.
	} state_e;

	state_e  state;
	winner_e winner;   // Registered outcome shown on LEDs and screen.
	winner_e verdict;  // Outcome that the current press pulses would give.
	digit_t  score_a;
	digit_t  score_b;
	logic    start_ok; // Start press in a state that accepts it.

	function automatic digit_t clamp_start(input logic [3:0] v);
		if (v > 4'd9) return 4'd9; // Switch values above nine saturate.
		if (v == 4'd0) return 4'd1; // A zero countdown would arm at once.
		return v;
	endfunction

	function automatic digit_t inc_mod10(input digit_t d);
		return (d == 4'd9) ? 4'd0 : d + 4'd1; // Scores wrap after nine.
	endfunction

	assign start_ok = press.start && (state == st_idle || state == st_result);

	// A single early press hands the round to the other player.
	always_comb begin
		verdict = win_none;
		if (press.player_a && press.player_b) begin
			verdict = win_tie; // Same-cycle presses tie early or late.
		end else if (press.player_a) begin
			verdict = (state == st_armed) ? win_a : win_b;
		end else if (press.player_b) begin
			verdict = (state == st_armed) ? win_b : win_a;
		end
	end

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
			winner <= win_none;
			score_a <= '0;
			score_b <= '0;
			load <= 1'b0;
		end else begin
			load <= 1'b0; // Load is a single-cycle pulse.
			case (state)
				st_idle, st_result: begin
					if (start_ok) begin
						state <= st_counting;
						winner <= win_none; // Clear the old result for the new round.
						load <= 1'b1;
					end
				end
				st_counting, st_armed: begin
					if (verdict != win_none) begin
						state <= st_result; // A press beats a done in the same cycle.
						winner <= verdict;
						if (verdict == win_a) score_a <= inc_mod10(score_a);
						if (verdict == win_b) score_b <= inc_mod10(score_b);
					end else if (state == st_counting && done) begin
						state <= st_armed;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (start_ok) load_value <= clamp_start(start_value); // Valid when load rises.
	end

	assign status = '{
		winner: winner,
		counting: (state == st_counting),
		score_a: score_a,
		score_b: score_b
	};

endmodule

`default_nettype wire

/* design/video_driver.sv */
`timescale 1ns/1ps
`default_nettype none

module video_driver
	import party_pkg::*;
#(
	parameter int WIDTH = 640, // Visible pixels per line.
	parameter int HEIGHT = 480 // Visible lines per frame.
) (
	input  wire        CLOCK_50,
	input  wire        arst_n,
	input  wire  rgb_t colour,      // Colour for the whole visible area.
	output logic [7:0] vga_r,
	output logic [7:0] vga_g,
	output logic [7:0] vga_b,
	output logic       vga_blank_n, // High inside the visible area.
	output logic       vga_clk,     // 25 MHz pixel clock.
	output logic       vga_hs,      // Active-low horizontal sync.
	output logic       vga_vs       // Active-low vertical sync.
);

	localparam int H_FRONT = 16; // Standard 640x480 at 60 Hz porches.
	localparam int H_SYNC = 96;
	localparam int H_TOTAL = 800;
	localparam int V_FRONT = 10;
	localparam int V_SYNC = 2;
	localparam int V_TOTAL = 525;

	localparam logic [9:0] H_LAST = 10'(H_TOTAL - 1);
	localparam logic [9:0] V_LAST = 10'(V_TOTAL - 1);
	localparam logic [9:0] H_ACTIVE = 10'(WIDTH);
	localparam logic [9:0] V_ACTIVE = 10'(HEIGHT);
	localparam logic [9:0] HS_START = 10'(WIDTH + H_FRONT);
	localparam logic [9:0] HS_END = 10'(WIDTH + H_FRONT + H_SYNC);
	localparam logic [9:0] VS_START = 10'(HEIGHT + V_FRONT);
	localparam logic [9:0] VS_END = 10'(HEIGHT + V_FRONT + V_SYNC);

	logic [9:0] h_cnt;  // Pixel position within the line.
	logic [9:0] v_cnt;  // Line position within the frame.
	logic       pix_en; // One CLOCK_50 cycle per pixel.
	logic       active; // Current pixel lies in the visible area.
	logic       hs_on;  // Inside the horizontal sync pulse.
	logic       vs_on;  // Inside the vertical sync pulse.

	assign pix_en = vga_clk; // Advance on the edge that drops the pixel clock.
	assign active = (h_cnt < H_ACTIVE) && (v_cnt < V_ACTIVE);
	assign hs_on = (h_cnt >= HS_START) && (h_cnt < HS_END);
	assign vs_on = (v_cnt >= VS_START) && (v_cnt < VS_END);

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			vga_clk <= 1'b0;
			h_cnt <= '0;
			v_cnt <= '0;
		end else begin
			vga_clk <= ~vga_clk; // Halves CLOCK_50 into the pixel clock.
			if (pix_en) begin
				if (h_cnt == H_LAST) begin
					h_cnt <= '0;
					v_cnt <= (v_cnt == V_LAST) ? 10'd0 : v_cnt + 10'd1; // Wraps at frame end.
				end else begin
					h_cnt <= h_cnt + 10'd1;
				end
			end
		end
	end

	// All pins change together so blanking and colour line up on the DAC.
	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			vga_hs <= 1'b1;
			vga_vs <= 1'b1;
			vga_blank_n <= 1'b0;
			vga_r <= '0;
			vga_g <= '0;
			vga_b <= '0;
		end else if (pix_en) begin
			vga_hs <= ~hs_on;
			vga_vs <= ~vs_on;
			vga_blank_n <= active;
			vga_r <= active ? colour.r : 8'h00; // Black in the porches and sync.
			vga_g <= active ? colour.g : 8'h00;
			vga_b <= active ? colour.b : 8'h00;
		end
	end

endmodule

`default_nettype wire

/* list.f */
+incdir+test
design/party_pkg.sv
design/button_sync.sv
design/countdown_timer.sv
design/round_control.sv
design/hex_display.sv
design/video_driver.sv
design/party_box.sv
test/tb_party_box.sv

/* test/party_model.svh */
`ifndef PARTY_MODEL_SVH
`define PARTY_MODEL_SVH

localparam int W_NONE = 0; // No result in this round yet.
localparam int W_A = 1;
localparam int W_B = 2;
localparam int W_TIE = 3;

int exp_score_a = 0; // Expected wins of player A modulo ten.
int exp_score_b = 0; // Expected wins of player B modulo ten.

function automatic int clamp_value(input int sw);
	if (sw > 9) return 9; // Large switch values saturate at nine.
	if (sw == 0) return 1; // A zero start still gives one step.
	return sw;
endfunction

// Lit segments in g f e d c b a order, inverted for the active-low pins.
function automatic logic [6:0] seg_pattern(input int d);
	logic [6:0] lit;
	case (d)
		0: lit = 7'b0111111;
		1: lit = 7'b0000110;
		2: lit = 7'b1011011;
		3: lit = 7'b1001111;
		4: lit = 7'b1100110;
		5: lit = 7'b1101101;
		6: lit = 7'b1111101;
		7: lit = 7'b0000111;
		8: lit = 7'b1111111;
		9: lit = 7'b1101111;
		default: lit = 7'b0000000;
	endcase
	return ~lit;
endfunction

function automatic int decide(input bit a, input bit b, input bit early);
	if (a && b) return W_TIE; // Same-cycle presses tie, early or not.
	if (a) return early ? W_B : W_A; // An early press gives the round away.
	return early ? W_A : W_B;
endfunction

function automatic void update_scores(input int w);
	if (w == W_A) exp_score_a = (exp_score_a + 1) % 10;
	if (w == W_B) exp_score_b = (exp_score_b + 1) % 10;
endfunction

function automatic logic [9:0] led_for(input int w);
	case (w)
		W_A: return 10'h3e0; // Left half for player A.
		W_B: return 10'h01f; // Right half for player B.
		W_TIE: return 10'h3ff;
		default: return 10'h000;
	endcase
endfunction

function automatic logic [23:0] colour_for(input int w);
	case (w)
		W_A: return 24'hff0000; // Red.
		W_B: return 24'h0000ff; // Blue.
		W_TIE: return 24'h00ff00; // Green.
		default: return 24'hffffff; // White while nobody has won.
	endcase
endfunction

`endif

/* test/tb_party_box.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_party_box;

	`include "party_model.svh"

	localparam int TICKS = 20; // Short countdown steps for simulation.
	localparam int DEBOUNCE = 4;
	localparam int ROUNDS = 40; // Enough wins per player to wrap the scores.
	localparam int FRAME = 800 * 525 * 2; // CLOCK_50 cycles in one video frame.
	localparam int LIMIT = ROUNDS * (10 * TICKS + 200) + 2 * FRAME;

	logic        CLOCK_50 = 1'b0;
	logic        arst_n;
	logic  [3:0] KEY;
	logic  [9:0] SW;
	logic [35:0] GPIO_1;
	wire   [6:0] HEX0, HEX1, HEX2, HEX3, HEX4, HEX5;
	wire   [9:0] LEDR;
	wire   [7:0] VGA_R, VGA_G, VGA_B;
	wire         VGA_BLANK_N, VGA_CLK, VGA_HS, VGA_SYNC_N, VGA_VS;

	int seed = 85168;
	int errors = 0;

	party_box #(.TICKS_PER_STEP(TICKS), .DEBOUNCE_CYCLES(DEBOUNCE)) i_party_box (.*);

	always #5 CLOCK_50 = ~CLOCK_50; // 10 ns period.

	function automatic int pick(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			errors++;
			$display("error %s expected %h got %h", name, exp, act);
		end
	endtask

	task automatic report(input string what);
		errors++;
		$display("%s", what);
	endtask

	// Each bit is driven on its own so that parallel presses do not collide.
	task automatic hold_press(input logic [3:0] keys, input logic buzz);
		@(posedge CLOCK_50);
		for (int i = 0; i < 4; i++) begin
			if (keys[i]) KEY[i] <= 1'b0; // Keys pull low when pressed.
		end
		if (buzz) GPIO_1[0] <= 1'b1;
		repeat (10) @(posedge CLOCK_50);
		for (int i = 0; i < 4; i++) begin
			if (keys[i]) KEY[i] <= 1'b1;
		end
		if (buzz) GPIO_1[0] <= 1'b0;
		repeat (10) @(posedge CLOCK_50); // The release must settle in the debouncer too.
	endtask

	task automatic check_countdown(input int first);
		int d;
		int held;
		d = first;
		held = 0;
		while (HEX0 !== seg_pattern(first)) begin
			@(negedge CLOCK_50);
			held++;
			if (held > 40) begin
				report("countdown did not start from the clamped value");
				return;
			end
		end
		held = 1;
		while (d > 0) begin
			@(negedge CLOCK_50);
			if (HEX0 === seg_pattern(d)) begin
				held++;
				if (held > TICKS + 2) begin
					report("countdown did not reach zero in time");
					return;
				end
			end else begin
				compare_value("HEX0", seg_pattern(d - 1), HEX0);
				compare_value("step_length", TICKS, held); // Every digit lasts one full step.
				d--;
				held = 1;
			end
		end
	endtask

	task automatic check_colour(input logic [23:0] exp);
		int waited;
		waited = 0;
		@(negedge CLOCK_50);
		while (VGA_BLANK_N !== 1'b1) begin
			@(negedge CLOCK_50);
			waited++;
			if (waited > FRAME) begin
				report("VGA_BLANK_N never went high within a frame");
				return;
			end
		end
		compare_value("VGA_RGB", exp, {VGA_R, VGA_G, VGA_B});
	endtask

	// Measures one whole frame from one vertical sync edge to the next.
	task automatic check_frame();
		int cycles;
		int lines;
		int lit;
		int stuck;
		int dirty;
		int waited;
		logic clk_prev;
		logic hs_prev;
		logic vs_prev;
		cycles = 0;
		lines = 0;
		lit = 0;
		stuck = 0;
		dirty = 0;
		waited = 0;
		vs_prev = 1'b0;
		@(negedge CLOCK_50);
		while (!(vs_prev === 1'b1 && VGA_VS === 1'b0)) begin
			vs_prev = VGA_VS;
			@(negedge CLOCK_50);
			waited++;
			if (waited > FRAME) begin
				report("VGA_VS never pulsed within a frame");
				return;
			end
		end
		clk_prev = VGA_CLK;
		hs_prev = VGA_HS;
		do begin
			vs_prev = VGA_VS;
			@(negedge CLOCK_50);
			cycles++;
			if (VGA_CLK === clk_prev) stuck++; // Pixel clock flips on every CLOCK_50 edge.
			if (hs_prev === 1'b1 && VGA_HS === 1'b0) lines++; // One sync pulse per line.
			if (VGA_BLANK_N === 1'b1) begin
				lit++;
			end else if ({VGA_R, VGA_G, VGA_B} !== 24'h000000) begin
				dirty++; // Colour must be black outside the visible area.
			end
			clk_prev = VGA_CLK;
			hs_prev = VGA_HS;
		end while (!(vs_prev === 1'b1 && VGA_VS === 1'b0) && cycles <= FRAME);
		compare_value("VGA_SYNC_N", 32'h1, VGA_SYNC_N);
		compare_value("frame_cycles", FRAME, cycles);
		compare_value("hs_pulses", 525, lines);
		compare_value("blank_n_cycles", 640 * 480 * 2, lit); // Two CLOCK_50 cycles per pixel.
		compare_value("vga_clk_repeats", 0, stuck);
		compare_value("rgb_in_blanking", 0, dirty);
	endtask

	initial begin
		int sw;
		int first;
		int delay;
		int winner;
		bit a;
		bit b;
		bit early;
		bit buzz;
		bit extra;
		logic [3:0] mask;
		KEY = 4'hf; // All keys released.
		SW = '0;
		GPIO_1 = '0;
		arst_n = 1'b0;
		repeat (2) @(posedge CLOCK_50);
		arst_n <= 1'b1;
		@(negedge CLOCK_50);
		compare_value("LEDR", 10'h000, LEDR);
		compare_value("HEX0", seg_pattern(0), HEX0);
		compare_value("HEX1", 7'h7f, HEX1);
		compare_value("HEX2", 7'h7f, HEX2);
		compare_value("HEX3", 7'h7f, HEX3);
		compare_value("HEX4", seg_pattern(0), HEX4);
		compare_value("HEX5", seg_pattern(0), HEX5);
		check_colour(colour_for(W_NONE));
		for (int r = 0; r < ROUNDS; r++) begin
			sw = (r == 0) ? 0 : ((r < 7) ? 9 + r : pick(16)); // Zero and 10 to 15 come first.
			first = clamp_value(sw);
			early = (pick(4) == 3); // One round in four is a false start.
			case (pick(3))
				0: begin
					a = 1'b1;
					b = 1'b0;
				end
				1: begin
					a = 1'b0;
					b = 1'b1;
				end
				default: begin
					a = 1'b1;
					b = 1'b1;
				end
			endcase
			buzz = pick(2); // Player A uses the buzzer or KEY[3].
			extra = pick(2); // Extra start press that must be ignored.
			mask = {a && !buzz, b, 2'b00};
			delay = early ? pick(TICKS * first - 12) : pick(TICKS * first);
			winner = decide(a, b, early);
			update_scores(winner);
			@(posedge CLOCK_50);
			SW <= 10'(sw);
			fork
				hold_press(4'b0001, 1'b0);
				check_countdown(first);
				begin
					if (early) begin
						repeat (12 + delay) @(posedge CLOCK_50); // Lands well before zero.
						hold_press(mask, a && buzz);
					end else if (extra) begin
						repeat (20 + delay) @(posedge CLOCK_50);
						hold_press(4'b0001, 1'b0);
					end
				end
			join
			if (!early) begin
				@(negedge CLOCK_50);
				compare_value("LEDR", 10'h000, LEDR); // Armed and nobody pressed yet.
				repeat (pick(8)) @(posedge CLOCK_50);
				hold_press(mask, a && buzz);
			end
			@(negedge CLOCK_50);
			if (LEDR === 10'h000) begin
				report("no result shown after the player press");
			end else begin
				compare_value("LEDR", led_for(winner), LEDR);
			end
			compare_value("HEX0", seg_pattern(0), HEX0);
			compare_value("HEX5", seg_pattern(exp_score_a), HEX5);
			compare_value("HEX4", seg_pattern(exp_score_b), HEX4);
			check_colour(colour_for(winner));
		end
		check_frame();
		$display("errors: %0d after %0d rounds", errors, ROUNDS);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		repeat (LIMIT) @(posedge CLOCK_50);
		$display("errors: %0d, watchdog expired before the rounds finished", errors);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire
